// ==== src/apb_pkg.sv ====
/*
 * APB bus definitions
 * Address, data and strobe widths, their vector types and the
 * access state encoding used by the slave FSM
 */

`default_nettype none

package apb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int PADDR_W = 12;
  localparam int PDATA_W = 32;
  // One strobe per byte lane
  localparam int PSTRB_W = PDATA_W / 8;

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [PDATA_W-1:0] pdata_t;
  typedef logic [PSTRB_W-1:0] pstrb_t;

  // Slave side of the setup/access handshake
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_ACCESS,
    APB_READ_WAIT
  } apb_state_t;

endpackage

`default_nettype wire

// ==== src/gpio_pkg.sv ====
/*
 * GPIO register map
 * Word indices and byte addresses of the GPIO registers
 */

`default_nettype none

package gpio_pkg;

  // Word index sits in address bits 4..2
  localparam int REG_IDX_LSB = 2;
  localparam int REG_IDX_W   = 3;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Word indices, 6 and 7 unmapped
  localparam reg_idx_t REG_MODE    = 3'd0;
  localparam reg_idx_t REG_DIR     = 3'd1;
  localparam reg_idx_t REG_OUT     = 3'd2;
  localparam reg_idx_t REG_IN      = 3'd3;
  localparam reg_idx_t REG_IOC_EN  = 3'd4;
  localparam reg_idx_t REG_PENDING = 3'd5;

  // Byte addresses as seen on PADDR
  localparam apb_pkg::paddr_t ADDR_MODE    = 12'h000;
  localparam apb_pkg::paddr_t ADDR_DIR     = 12'h004;
  localparam apb_pkg::paddr_t ADDR_OUT     = 12'h008;
  localparam apb_pkg::paddr_t ADDR_IN      = 12'h00C;
  localparam apb_pkg::paddr_t ADDR_IOC_EN  = 12'h010;
  localparam apb_pkg::paddr_t ADDR_PENDING = 12'h014;

endpackage

`default_nettype wire

// ==== src/gpio_reg_if.sv ====
/*
 * GPIO register access interface
 * One register read or write from the APB FSM to the register bank
 */

`timescale 1ns/1ns
`default_nettype none

interface gpio_reg_if #(
  parameter int GPIO_WIDTH = 16
);
  import apb_pkg::*;
  import gpio_pkg::*;

  // Request side, from the FSM
  logic     wr_en;
  logic     rd_en;
  reg_idx_t idx;
  logic     addr_hi_nonzero;
  pdata_t   wdata;
  pstrb_t   strb;

  // Response side, from the bank
  pdata_t   rdata;
  logic     err;

  // Byte strobes spread to one enable per pin
  logic [GPIO_WIDTH-1:0] wmask;

  always_comb begin
    for (int i = 0; i < GPIO_WIDTH; i++) begin
      wmask[i] = strb[i / 8];
    end
  end

  modport fsm (
    output wr_en, rd_en, idx, addr_hi_nonzero, wdata, strb,
    input  rdata, err
  );

  modport bank (
    input  wr_en, rd_en, idx, addr_hi_nonzero, wdata, wmask,
    output rdata, err
  );

endinterface

`default_nettype wire

// ==== src/gpio_apb_fsm.sv ====
/*
 * APB slave FSM
 * Turns each APB transfer into one register access, zero wait
 * states on writes and one wait state on reads
 */

`timescale 1ns/1ns
`default_nettype none

module gpio_apb_fsm (
  input  wire logic            PCLK,
  input  wire logic            PRESETn,
  input  wire logic            psel,
  input  wire logic            penable,
  input  wire logic            pwrite,
  input  wire apb_pkg::paddr_t paddr,
  input  wire apb_pkg::pdata_t pwdata,
  input  wire apb_pkg::pstrb_t pstrb,
  output apb_pkg::pdata_t      prdata,
  output logic                 pready,
  output logic                 pslverr,
  gpio_reg_if.fsm              regs
);
  import apb_pkg::*;
  import gpio_pkg::*;

  apb_state_t state_q;
  apb_state_t state_d;

  ////////////////////////////////////////////////////////////////////////////
  // Request fields, straight from the bus
  ////////////////////////////////////////////////////////////////////////////

  // Bank decides what is mapped, FSM only splits the address
  assign regs.idx             = paddr[REG_IDX_LSB +: REG_IDX_W];
  assign regs.addr_hi_nonzero = |paddr[PADDR_W-1:REG_IDX_LSB+REG_IDX_W];
  assign regs.wdata           = pwdata;
  assign regs.strb            = pstrb;

  // Read data already registered in the bank
  assign prdata = regs.rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and handshake
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    regs.wr_en = 1'b0;
    regs.rd_en = 1'b0;
    pready     = 1'b0;
    pslverr    = 1'b0;
    case (state_q)
      APB_IDLE: begin
        // Setup phase seen
        if (psel && !penable) begin
          state_d = APB_ACCESS;
        end
      end
      APB_ACCESS: begin
        if (psel && penable && pwrite) begin
          // Write completes in this cycle
          regs.wr_en = 1'b1;
          pready     = 1'b1;
          pslverr    = regs.err;
          state_d    = APB_IDLE;
        end else if (psel && penable) begin
          regs.rd_en = 1'b1;
          state_d    = APB_READ_WAIT;
        end else begin
          // Master dropped the transfer
          state_d = APB_IDLE;
        end
      end
      APB_READ_WAIT: begin
        // Address still held, so err is still valid
        pready  = 1'b1;
        pslverr = regs.err;
        state_d = APB_IDLE;
      end
      default: state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      state_q <= APB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/gpio_sample_timer.sv ====
/*
 * Sample timer
 * Fixed prescaler, one-clock tick every SAMPLE_DIV clocks
 */

`timescale 1ns/1ns
`default_nettype none

module gpio_sample_timer #(
  parameter int SAMPLE_DIV = 4
) (
  input  wire logic PCLK,
  input  wire logic PRESETn,
  output logic      tick
);

  localparam int CNT_W = $clog2(SAMPLE_DIV);

  typedef logic [CNT_W-1:0] cnt_t;

  // Counter runs SAMPLE_DIV-1 down to 0
  localparam cnt_t RELOAD = cnt_t'(SAMPLE_DIV - 1);

  cnt_t cnt_q;

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      cnt_q <= RELOAD;
      tick  <= 1'b0;
    end else begin
      // Tick registered, period stays SAMPLE_DIV
      tick <= (cnt_q == '0);
      if (cnt_q == '0) begin
        cnt_q <= RELOAD;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/gpio_input_stage.sv ====
/*
 * GPIO input stage
 * Three-flop synchronizer, tick-sampled register and change detect
 */

`timescale 1ns/1ns
`default_nettype none

module gpio_input_stage #(
  parameter int GPIO_WIDTH = 16
) (
  input  wire logic                  PCLK,
  input  wire logic                  PRESETn,
  input  wire logic [GPIO_WIDTH-1:0] gpio_i,
  input  wire logic                  tick,
  output logic [GPIO_WIDTH-1:0]      in_sync,
  output logic [GPIO_WIDTH-1:0]      change
);

  typedef logic [GPIO_WIDTH-1:0] pins_t;

  pins_t sync1_q;
  pins_t sync2_q;
  pins_t sync3_q;
  pins_t sample_q;
  logic  seeded_q;

  ////////////////////////////////////////////////////////////////////////////
  // Synchronizer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      sync1_q <= '0;
      sync2_q <= '0;
      sync3_q <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
    end
  end

  // REG_IN reads the last stage
  assign in_sync = sync3_q;

  ////////////////////////////////////////////////////////////////////////////
  // Tick sampling and change detect
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      sample_q <= '0;
      seeded_q <= 1'b0;
      change   <= '0;
    end else begin
      // One-clock pulse per detected change
      change <= '0;
      if (tick) begin
        sample_q <= sync3_q;
        seeded_q <= 1'b1;
        // First tick only seeds the sample
        if (seeded_q) begin
          change <= sync3_q ^ sample_q;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/gpio_reg_bank.sv ====
/*
 * GPIO register bank
 * Mode, direction, output, IOC enable and pending registers,
 * read mux, registered pad drive and irq
 */

`timescale 1ns/1ns
`default_nettype none

module gpio_reg_bank #(
  parameter int GPIO_WIDTH = 16
) (
  input  wire logic                  PCLK,
  input  wire logic                  PRESETn,
  gpio_reg_if.bank                   regs,
  input  wire logic [GPIO_WIDTH-1:0] in_sync,
  input  wire logic [GPIO_WIDTH-1:0] change,
  output logic [GPIO_WIDTH-1:0]      gpio_o,
  output logic [GPIO_WIDTH-1:0]      gpio_oe,
  output logic                       irq
);
  import apb_pkg::*;
  import gpio_pkg::*;

  typedef logic [GPIO_WIDTH-1:0] pins_t;

  pins_t  mode_q;
  pins_t  dir_q;
  pins_t  out_q;
  pins_t  ioc_en_q;
  pins_t  pend_q;
  pins_t  wr_bits;
  pins_t  clr_bits;
  pins_t  rd_mux;
  pdata_t rdata_q;
  logic   wr_ok;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and write data
  ////////////////////////////////////////////////////////////////////////////

  // Indices 6, 7 and anything above bit 4 unmapped
  assign regs.err = regs.addr_hi_nonzero || (regs.idx > REG_PENDING);

  assign wr_ok   = regs.wr_en && !regs.err;
  assign wr_bits = regs.wdata[GPIO_WIDTH-1:0];

  // Keep unstrobed bytes, take strobed ones
  function automatic pins_t merge(pins_t old_val, pins_t new_val, pins_t mask);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      mode_q   <= '0;
      dir_q    <= '0;
      out_q    <= '0;
      ioc_en_q <= '0;
    end else if (wr_ok) begin
      case (regs.idx)
        REG_MODE:   mode_q   <= merge(mode_q, wr_bits, regs.wmask);
        REG_DIR:    dir_q    <= merge(dir_q, wr_bits, regs.wmask);
        REG_OUT:    out_q    <= merge(out_q, wr_bits, regs.wmask);
        REG_IOC_EN: ioc_en_q <= merge(ioc_en_q, wr_bits, regs.wmask);
        // REG_IN is read only, PENDING handled below
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pending bits, write 1 to clear
  ////////////////////////////////////////////////////////////////////////////

  assign clr_bits = (wr_ok && regs.idx == REG_PENDING) ? (wr_bits & regs.wmask) : '0;

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      pend_q <= '0;
    end else begin
      // New change beats a clear on the same pin
      pend_q <= (pend_q & ~clr_bits) | change;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (regs.idx)
      REG_MODE:    rd_mux = mode_q;
      REG_DIR:     rd_mux = dir_q;
      REG_OUT:     rd_mux = out_q;
      REG_IN:      rd_mux = in_sync;
      REG_IOC_EN:  rd_mux = ioc_en_q;
      REG_PENDING: rd_mux = pend_q;
      default:     rd_mux = '0;
    endcase
  end

  // Loaded in the first access cycle, zero on error
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      rdata_q <= '0;
    end else if (regs.rd_en) begin
      rdata_q <= regs.err ? '0 : pdata_t'(rd_mux);
    end
  end

  assign regs.rdata = rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Pads and interrupt
  ////////////////////////////////////////////////////////////////////////////

  // Open drain pulls low only, released when output bit is 1
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      gpio_o  <= '0;
      gpio_oe <= '0;
      irq     <= 1'b0;
    end else begin
      gpio_o  <= out_q & ~mode_q;
      gpio_oe <= dir_q & ~(mode_q & out_q);
      irq     <= |(pend_q & ioc_en_q);
    end
  end

endmodule

`default_nettype wire

// ==== src/gpio_top.sv ====
/*
 * APB GPIO peripheral, top level
 * APB slave FSM, sample timer, input stage and register bank
 */

`timescale 1ns/1ns
`default_nettype none

module gpio_top #(
  parameter int GPIO_WIDTH = 16,
  parameter int SAMPLE_DIV = 4
) (
  input  wire logic                  PCLK,
  input  wire logic                  PRESETn,
  input  wire logic                  PSEL,
  input  wire logic                  PENABLE,
  input  wire logic                  PWRITE,
  input  wire apb_pkg::paddr_t       PADDR,
  input  wire apb_pkg::pdata_t       PWDATA,
  input  wire apb_pkg::pstrb_t       PSTRB,
  output apb_pkg::pdata_t            PRDATA,
  output logic                       PREADY,
  output logic                       PSLVERR,
  input  wire logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0]      gpio_o,
  output logic [GPIO_WIDTH-1:0]      gpio_oe,
  output logic                       irq
);

  logic                  tick;
  logic [GPIO_WIDTH-1:0] in_sync;
  logic [GPIO_WIDTH-1:0] change;

  // FSM to bank register access
  gpio_reg_if #(.GPIO_WIDTH(GPIO_WIDTH)) reg_bus ();

  gpio_apb_fsm u_apb_fsm (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .psel    (PSEL),
    .penable (PENABLE),
    .pwrite  (PWRITE),
    .paddr   (PADDR),
    .pwdata  (PWDATA),
    .pstrb   (PSTRB),
    .prdata  (PRDATA),
    .pready  (PREADY),
    .pslverr (PSLVERR),
    .regs    (reg_bus.fsm)
  );

  gpio_sample_timer #(.SAMPLE_DIV(SAMPLE_DIV)) u_sample_timer (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .tick    (tick)
  );

  gpio_input_stage #(.GPIO_WIDTH(GPIO_WIDTH)) u_input_stage (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .gpio_i  (gpio_i),
    .tick    (tick),
    .in_sync (in_sync),
    .change  (change)
  );

  gpio_reg_bank #(.GPIO_WIDTH(GPIO_WIDTH)) u_reg_bank (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .regs    (reg_bus.bank),
    .in_sync (in_sync),
    .change  (change),
    .gpio_o  (gpio_o),
    .gpio_oe (gpio_oe),
    .irq     (irq)
  );

endmodule

`default_nettype wire

// ==== tb/tb_gpio_top.sv ====
/*
 * APB GPIO testbench
 * APB driver, reference model of registers and pads, and a compare
 * process covering reset, strobed writes, pads, inputs, IOC and errors
 */

`timescale 1ns/1ns
`default_nettype none

module tb_gpio_top;
  import apb_pkg::*;
  import gpio_pkg::*;

  localparam int GPIO_WIDTH = 16;
  localparam int SAMPLE_DIV = 4;
  // Transfers take at most 4 cycles, IOC waits about 10 ticks each
  localparam int N_XFERS     = 200;
  localparam int N_IOC_WAITS = 5;
  localparam int WATCHDOG_CYCLES = 16 + N_XFERS * 4 + N_IOC_WAITS * 10 * SAMPLE_DIV + 200;

  logic                  PCLK;
  logic                  PRESETn;
  logic                  PSEL;
  logic                  PENABLE;
  logic                  PWRITE;
  paddr_t                PADDR;
  pdata_t                PWDATA;
  pstrb_t                PSTRB;
  pdata_t                PRDATA;
  logic                  PREADY;
  logic                  PSLVERR;
  logic [GPIO_WIDTH-1:0] gpio_i;
  logic [GPIO_WIDTH-1:0] gpio_o;
  logic [GPIO_WIDTH-1:0] gpio_oe;
  logic                  irq;

  logic [31:0] rng_state;
  int          value_errors;
  int          protocol_errors;
  // Register model by word index
  logic [15:0] model_regs [0:5];

  // Pending comparisons, filled by the tests
  string       name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];

  gpio_top #(.GPIO_WIDTH(GPIO_WIDTH), .SAMPLE_DIV(SAMPLE_DIV)) UUT (
    .PCLK(PCLK), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .PADDR(PADDR), .PWDATA(PWDATA), .PSTRB(PSTRB), .PRDATA(PRDATA), .PREADY(PREADY),
    .PSLVERR(PSLVERR), .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe(gpio_oe), .irq(irq)
  );

  always #10 PCLK = ~PCLK;

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Register value after a strobed write, one byte lane per 8 pins
  function automatic logic [15:0] expect_merge(logic [15:0] old_val, logic [31:0] data,
                                               pstrb_t strb);
    logic [15:0] res;
    for (int i = 0; i < GPIO_WIDTH; i++) begin
      res[i] = strb[i / 8] ? data[i] : old_val[i];
    end
    return res;
  endfunction

  // Open drain never drives high
  function automatic logic [15:0] expect_pad_o(logic [15:0] mode, logic [15:0] out);
    logic [15:0] res;
    for (int i = 0; i < GPIO_WIDTH; i++) begin
      res[i] = mode[i] ? 1'b0 : out[i];
    end
    return res;
  endfunction

  // Open drain releases the pad for a 1
  function automatic logic [15:0] expect_pad_oe(logic [15:0] mode, logic [15:0] dir,
                                                logic [15:0] out);
    logic [15:0] res;
    for (int i = 0; i < GPIO_WIDTH; i++) begin
      res[i] = (mode[i] && out[i]) ? 1'b0 : dir[i];
    end
    return res;
  endfunction

  function automatic paddr_t reg_addr(int idx);
    return paddr_t'(idx * 4);
  endfunction

  task automatic expect_value(string name, logic [31:0] exp_val, logic [31:0] act_val);
    name_q.push_back(name);
    exp_q.push_back(exp_val);
    act_q.push_back(act_val);
  endtask

  always @(posedge PCLK) begin : compare_results
    string       name;
    logic [31:0] exp_val;
    logic [31:0] act_val;
    while (name_q.size() > 0) begin
      name    = name_q.pop_front();
      exp_val = exp_q.pop_front();
      act_val = act_q.pop_front();
      assert (act_val === exp_val) else begin
        value_errors++;
        $display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////////////////////

  // Setup, access, then wait for PREADY sampled mid-cycle
  task automatic apb_xfer(input logic wr, input paddr_t addr, input pdata_t data,
                          input pstrb_t strb, output pdata_t rdata, output logic err);
    int waits;
    @(posedge PCLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= wr;
    PADDR   <= addr;
    PWDATA  <= data;
    PSTRB   <= wr ? strb : '0;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    waits = 0;
    @(negedge PCLK);
    while (PREADY !== 1'b1 && waits < 8) begin
      waits++;
      @(negedge PCLK);
    end
    // Writes complete at once, reads after one wait state
    assert (waits == (wr ? 0 : 1)) else begin
      protocol_errors++;
      $display("Transfer to %h ended after %0d wait states, expected %0d",
               addr, waits, wr ? 0 : 1);
    end
    rdata = PRDATA;
    err   = PSLVERR;
    @(posedge PCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
  endtask

  task automatic apb_write(input paddr_t addr, input pdata_t data, input pstrb_t strb,
                           output logic err);
    pdata_t unused;
    apb_xfer(1'b1, addr, data, strb, unused, err);
  endtask

  task automatic apb_read(input paddr_t addr, output pdata_t data, output logic err);
    apb_xfer(1'b0, addr, '0, '0, data, err);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge PCLK);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    pdata_t      rd;
    logic        err;
    logic [31:0] data;
    pstrb_t      strb;
    logic [15:0] mask;
    logic [15:0] en;
    int          polls;
    PCLK = 1'b0;
    PRESETn = 1'b0;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = '0;
    PWDATA = '0;
    PSTRB = '0;
    gpio_i = '0;
    rng_state = 32'h3390fad0;
    value_errors = 0;
    protocol_errors = 0;
    for (int r = 0; r < 6; r++) begin
      model_regs[r] = '0;
    end
    repeat (16) @(posedge PCLK);
    PRESETn <= 1'b1;

    // Reset state
    for (int r = 0; r < 6; r++) begin
      apb_read(reg_addr(r), rd, err);
      expect_value($sformatf("reset idx %0d", r), 32'h0, rd);
    end
    @(negedge PCLK);
    expect_value("reset gpio_o", 32'h0, gpio_o);
    expect_value("reset gpio_oe", 32'h0, gpio_oe);
    expect_value("reset irq", 32'h0, irq);

    // Strobed writes to the read/write registers
    for (int r = 0; r < 6; r++) begin
      if (r == REG_IN || r == REG_PENDING) begin
        continue;
      end
      repeat (4) begin
        data = next_rand();
        strb = pstrb_t'(next_rand() >> 28);
        apb_write(reg_addr(r), data, strb, err);
        model_regs[r] = expect_merge(model_regs[r], data, strb);
        apb_read(reg_addr(r), rd, err);
        expect_value($sformatf("strobed write idx %0d", r), {16'h0, model_regs[r]}, rd);
      end
    end
    // Pins held low since reset, so REG_IN stays at the pin value
    apb_write(ADDR_IN, next_rand(), 4'hF, err);
    apb_read(ADDR_IN, rd, err);
    expect_value("REG_IN write ignored", {16'h0, gpio_i}, rd);

    // Pad drive from mode, direction and output
    repeat (4) begin
      for (int r = REG_MODE; r <= REG_OUT; r++) begin
        data = next_rand();
        apb_write(reg_addr(r), data, 4'hF, err);
        model_regs[r] = expect_merge(model_regs[r], data, 4'hF);
      end
      repeat (2) @(posedge PCLK);
      @(negedge PCLK);
      expect_value("pad gpio_o", expect_pad_o(model_regs[REG_MODE], model_regs[REG_OUT]),
                   gpio_o);
      expect_value("pad gpio_oe", expect_pad_oe(model_regs[REG_MODE], model_regs[REG_DIR],
                   model_regs[REG_OUT]), gpio_oe);
    end

    // Input path through the synchronizer
    repeat (4) begin
      data = next_rand();
      @(posedge PCLK);
      gpio_i <= data[15:0];
      repeat (5) @(posedge PCLK);
      apb_read(ADDR_IN, rd, err);
      expect_value("REG_IN after sync", {16'h0, data[15:0]}, rd);
    end

    // Interrupt-on-change, low byte enabled only
    en = 16'h00FF;
    apb_write(ADDR_IOC_EN, {16'h0, en}, 4'hF, err);
    model_regs[REG_IOC_EN] = en;
    repeat (4 + 2 * SAMPLE_DIV + 4) @(posedge PCLK);
    apb_write(ADDR_PENDING, 32'h0000_FFFF, 4'hF, err);
    repeat (2) @(posedge PCLK);
    apb_read(ADDR_PENDING, rd, err);
    expect_value("pending before IOC", 32'h0, rd);
    @(negedge PCLK);
    expect_value("irq before IOC", 32'h0, irq);
    for (int r = 0; r < 4; r++) begin
      data = next_rand();
      // Even rounds miss the enables, odd rounds hit them
      mask = (r % 2 == 0) ? ((data[15:0] & 16'hFF00) | 16'h8000) : (data[15:0] | 16'h0001);
      @(posedge PCLK);
      gpio_i <= gpio_i ^ mask;
      polls = 0;
      rd = '0;
      while (rd[15:0] != mask && polls < 20) begin
        apb_read(ADDR_PENDING, rd, err);
        polls++;
      end
      expect_value("pending after toggle", {16'h0, mask}, rd);
      repeat (2) @(posedge PCLK);
      @(negedge PCLK);
      expect_value("irq on change", {31'h0, |(mask & en)}, irq);
      apb_write(ADDR_PENDING, {16'h0, mask}, 4'hF, err);
      repeat (2) @(posedge PCLK);
      apb_read(ADDR_PENDING, rd, err);
      expect_value("pending after clear", 32'h0, rd);
      @(negedge PCLK);
      expect_value("irq after clear", 32'h0, irq);
    end

    // Unmapped word index 6 and address above bit 4
    apb_write(12'h018, next_rand(), 4'hF, err);
    expect_value("PSLVERR write idx 6", 32'h1, err);
    apb_read(12'h018, rd, err);
    expect_value("PSLVERR read idx 6", 32'h1, err);
    expect_value("read data idx 6", 32'h0, rd);
    apb_write(12'h100, next_rand(), 4'hF, err);
    expect_value("PSLVERR write 0x100", 32'h1, err);
    apb_read(12'h100, rd, err);
    expect_value("PSLVERR read 0x100", 32'h1, err);
    expect_value("read data 0x100", 32'h0, rd);
    for (int r = 0; r < 6; r++) begin
      if (r == REG_IN) begin
        continue;
      end
      apb_read(reg_addr(r), rd, err);
      expect_value($sformatf("kept after unmapped idx %0d", r), {16'h0, model_regs[r]}, rd);
    end

    // Let the compare process drain its queue
    repeat (2) @(posedge PCLK);
    $display("Errors: value %0d, protocol %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
src/apb_pkg.sv
src/gpio_pkg.sv
src/gpio_reg_if.sv
src/gpio_apb_fsm.sv
src/gpio_sample_timer.sv
src/gpio_input_stage.sv
src/gpio_reg_bank.sv
src/gpio_top.sv
tb/tb_gpio_top.sv
